// File: logic/mixer_pkg.sv
package mixer_pkg;

    // palette geometry
    localparam int pal_aw = 10;
    localparam int pal_dw = 16;
    localparam int pal_depth = 1 << pal_aw;

    // one colour channel in the palette word
    localparam int ch_w = 4;

    // source layer, doubles as palette address bits 9:8
    typedef enum logic [1:0] {
        layer_obj = 2'd0,
        layer_ba0 = 2'd1,
        layer_ba1 = 2'd2,
        layer_ba2 = 2'd3
    } layer_sel_t;

    // front text and scroll layers
    typedef struct packed {
        logic [3:0] pal;
        logic [3:0] col;
    } tile_pixel_t;

    // sprite layer, msb is the priority flag
    typedef struct packed {
        logic       prio;
        logic [2:0] pal;
        logic [3:0] col;
    } sprite_pixel_t;

    // same 8-bit word, decoded per layer kind
    // col == 0 is transparent in both views
    typedef union packed {
        tile_pixel_t   tile;
        sprite_pixel_t spr;
    } layer_pixel_t;

endpackage

// File: logic/layer_priority.sv
`timescale 1ns/100ps

module layer_priority (
    input  logic                         clk,
    input  logic                         pxl_cen,
    input  mixer_pkg::layer_pixel_t      ba0_pxl,
    input  mixer_pkg::layer_pixel_t      ba1_pxl,
    input  mixer_pkg::layer_pixel_t      ba2_pxl,
    input  mixer_pkg::layer_pixel_t      obj_pxl,
    input  logic [2:0]                   prisel,
    input  logic [3:0]                   gfx_en,
    output logic [mixer_pkg::pal_aw-1:0] pal_addr
);
    import mixer_pkg::*;

    // per-layer transparency, colour zero or layer disabled
    logic ba0_blank;
    logic ba1_blank;
    logic ba2_blank;
    logic obj_blank;
    // sprite goes behind solid scroll pixels
    logic obj_loprio;

    layer_sel_t   scr_sel;
    layer_pixel_t scr_pxl;
    layer_sel_t   sel;
    layer_pixel_t sel_pxl;

    assign ba0_blank = (ba0_pxl.tile.col == 4'd0) || !gfx_en[0];
    assign ba1_blank = (ba1_pxl.tile.col == 4'd0) || !gfx_en[1];
    assign ba2_blank = (ba2_pxl.tile.col == 4'd0) || !gfx_en[2];
    // sprite uses its own view of the word
    assign obj_blank = (obj_pxl.spr.col == 4'd0) || !gfx_en[3];

    assign obj_loprio = prisel[1] && (obj_pxl.spr.prio != prisel[2]);

    // scroll pair first
    always_comb begin
        if (prisel[0]) begin
            // ba2 in front
            scr_sel = ba2_blank ? layer_ba1 : layer_ba2;
        end else begin
            // ba1 in front
            scr_sel = ba1_blank ? layer_ba2 : layer_ba1;
        end
        // both blank still leaves the fallback layer selected
        scr_pxl = (scr_sel == layer_ba2) ? ba2_pxl : ba1_pxl;
    end

    // then sprite over scroll, then text over all
    always_comb begin
        sel = scr_sel;
        if (!(obj_blank || (obj_loprio && scr_pxl.tile.col != 4'd0))) begin
            sel = layer_obj;
        end
        if (!ba0_blank) begin
            sel = layer_ba0;
        end
    end

    // pixel of the winning layer
    always_comb begin
        case (sel)
            layer_obj: sel_pxl = obj_pxl;
            layer_ba0: sel_pxl = ba0_pxl;
            layer_ba1: sel_pxl = ba1_pxl;
            default:   sel_pxl = ba2_pxl;
        endcase
    end

    // palette index = {bank, pixel}
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pal_addr <= {sel, sel_pxl};
        end
    end

    // ram read address may only move on a pixel enable
    // so the colour seen by the output stage belongs to one pixel
    a_pal_addr_hold: assert property (
        @(posedge clk)
        (!pxl_cen && !$isunknown(pal_addr)) |=> $stable(pal_addr)
    );

endmodule

// File: logic/palette_apb_port.sv
`timescale 1ns/100ps

module palette_apb_port (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [11:0]                  paddr,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [mixer_pkg::pal_dw-1:0] pwdata,
    input  logic [1:0]                   pstrb,
    output logic [mixer_pkg::pal_dw-1:0] prdata,
    output logic                         pready,
    output logic                         pslverr,
    output logic [mixer_pkg::pal_aw-1:0] cpu_addr,
    output logic [mixer_pkg::pal_dw-1:0] cpu_wdata,
    output logic [1:0]                   cpu_we,
    output logic                         cpu_rd,
    input  logic [mixer_pkg::pal_dw-1:0] cpu_rdata
);
    import mixer_pkg::*;

    logic setup_ph;
    logic access_ph;
    // anything past bit 10 is outside the palette
    logic addr_err;
    // access cycle holds valid read data
    logic rd_ok;

    assign setup_ph  = psel && !penable;
    assign access_ph = psel && penable;
    assign addr_err  = paddr[11];

    // word index, byte address bit 0 dropped
    assign cpu_addr  = paddr[pal_aw:1];
    assign cpu_wdata = pwdata;

    // write commits at the end of the access cycle
    assign cpu_we = (access_ph && pwrite && !addr_err) ? pstrb : 2'b00;
    // read issued in setup, data back in access
    assign cpu_rd = setup_ph && !pwrite && !addr_err;

    // response flags line up with the access cycle, no wait states
    always_ff @(posedge clk) begin
        if (reset) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
            rd_ok   <= 1'b0;
        end else begin
            pready  <= setup_ph;
            pslverr <= setup_ph && addr_err;
            rd_ok   <= setup_ph && !pwrite && !addr_err;
        end
    end

    // errored or write accesses read back zero
    assign prdata = rd_ok ? cpu_rdata : '0;

    a_penable_needs_psel: assert property (
        @(posedge clk) disable iff (reset)
        $rose(penable) |-> psel
    );

    // address chosen in setup must still hold for the write and read data
    a_paddr_stable: assert property (
        @(posedge clk) disable iff (reset)
        setup_ph |=> (!penable || $stable(paddr))
    );

endmodule

// File: logic/palette_ram.sv
`timescale 1ns/100ps

module palette_ram (
    input  logic                         clk,
    // cpu port
    input  logic [mixer_pkg::pal_aw-1:0] cpu_addr,
    input  logic [mixer_pkg::pal_dw-1:0] cpu_wdata,
    input  logic [1:0]                   cpu_we,
    input  logic                         cpu_rd,
    output logic [mixer_pkg::pal_dw-1:0] cpu_rdata,
    // video port
    input  logic [mixer_pkg::pal_aw-1:0] pal_addr,
    output logic [mixer_pkg::pal_dw-1:0] pal_data
);
    import mixer_pkg::*;

    // 1024 x 16, contents undefined until the cpu loads them
    logic [pal_dw-1:0] mem [0:pal_depth-1];

    // cpu side, byte lanes written separately
    always_ff @(posedge clk) begin
        if (cpu_we[0]) begin
            mem[cpu_addr][7:0] <= cpu_wdata[7:0];
        end
        if (cpu_we[1]) begin
            mem[cpu_addr][15:8] <= cpu_wdata[15:8];
        end
        // registered read, only on request
        if (cpu_rd) begin
            cpu_rdata <= mem[cpu_addr];
        end
    end

    // video side, read every clock
    // a write to the same entry this clock is seen one read later
    always_ff @(posedge clk) begin
        pal_data <= mem[pal_addr];
    end

endmodule

// File: logic/video_output.sv
`timescale 1ns/100ps

module video_output #(
    parameter int blank_dly = 2
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         pxl_cen,
    input  logic                         lhbl,
    input  logic                         lvbl,
    input  logic [mixer_pkg::pal_dw-1:0] pal_data,
    output logic [7:0]                   red,
    output logic [7:0]                   green,
    output logic [7:0]                   blue,
    output logic                         lhbl_dly,
    output logic                         lvbl_dly
);
    import mixer_pkg::*;

    // {lhbl, lvbl} per stage
    logic [1:0] blank_sr [1:blank_dly];
    logic [1:0] blank_in;
    // what the last stage takes on this enable
    logic [1:0] blank_next;

    assign blank_in = {lhbl, lvbl};

    always_ff @(posedge clk) begin
        if (reset) begin
            // start out blanked
            for (int i = 1; i <= blank_dly; i++) begin
                blank_sr[i] <= 2'b00;
            end
        end else if (pxl_cen) begin
            blank_sr[1] <= blank_in;
            for (int i = 2; i <= blank_dly; i++) begin
                blank_sr[i] <= blank_sr[i-1];
            end
        end
    end

    generate
        if (blank_dly == 1) begin : g_dly_one
            assign blank_next = blank_in;
        end else begin : g_dly_many
            assign blank_next = blank_sr[blank_dly-1];
        end
    endgenerate

    assign lhbl_dly = blank_sr[blank_dly][1];
    assign lvbl_dly = blank_sr[blank_dly][0];

    // 4 to 8 bit expansion, nibble repeated
    // masked with the strobes that go out alongside it
    always_ff @(posedge clk) begin
        if (reset) begin
            red   <= 8'd0;
            green <= 8'd0;
            blue  <= 8'd0;
        end else if (pxl_cen) begin
            if (&blank_next) begin
                red   <= {2{pal_data[ch_w-1:0]}};
                green <= {2{pal_data[2*ch_w-1:ch_w]}};
                blue  <= {2{pal_data[3*ch_w-1:2*ch_w]}};
            end else begin
                red   <= 8'd0;
                green <= 8'd0;
                blue  <= 8'd0;
            end
        end
    end

    // palette read needs one clock between address and data
    a_cen_spacing: assert property (
        @(posedge clk) disable iff (reset)
        pxl_cen |=> !pxl_cen
    );

endmodule

// File: logic/video_mixer_top.sv
`timescale 1ns/100ps

module video_mixer_top #(
    parameter int blank_dly = 2
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         pxl_cen,
    // active-low blanking
    input  logic                         lhbl,
    input  logic                         lvbl,
    // layer pixels
    input  mixer_pkg::layer_pixel_t      ba0_pxl,
    input  mixer_pkg::layer_pixel_t      ba1_pxl,
    input  mixer_pkg::layer_pixel_t      ba2_pxl,
    input  mixer_pkg::layer_pixel_t      obj_pxl,
    input  logic [2:0]                   prisel,
    input  logic [3:0]                   gfx_en,
    // apb slave
    input  logic [11:0]                  paddr,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [mixer_pkg::pal_dw-1:0] pwdata,
    input  logic [1:0]                   pstrb,
    output logic [mixer_pkg::pal_dw-1:0] prdata,
    output logic                         pready,
    output logic                         pslverr,
    // video out
    output logic [7:0]                   red,
    output logic [7:0]                   green,
    output logic [7:0]                   blue,
    output logic                         lhbl_dly,
    output logic                         lvbl_dly
);

    // cpu to ram
    logic [mixer_pkg::pal_aw-1:0] cpu_addr;
    logic [mixer_pkg::pal_dw-1:0] cpu_wdata;
    logic [1:0]                   cpu_we;
    logic                         cpu_rd;
    logic [mixer_pkg::pal_dw-1:0] cpu_rdata;
    // video path
    logic [mixer_pkg::pal_aw-1:0] pal_addr;
    logic [mixer_pkg::pal_dw-1:0] pal_data;

    layer_priority u_layer_priority (
        .clk      (clk),
        .pxl_cen  (pxl_cen),
        .ba0_pxl  (ba0_pxl),
        .ba1_pxl  (ba1_pxl),
        .ba2_pxl  (ba2_pxl),
        .obj_pxl  (obj_pxl),
        .prisel   (prisel),
        .gfx_en   (gfx_en),
        .pal_addr (pal_addr)
    );

    palette_apb_port u_palette_apb_port (
        .clk       (clk),
        .reset     (reset),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .pstrb     (pstrb),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_we    (cpu_we),
        .cpu_rd    (cpu_rd),
        .cpu_rdata (cpu_rdata)
    );

    palette_ram u_palette_ram (
        .clk       (clk),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_we    (cpu_we),
        .cpu_rd    (cpu_rd),
        .cpu_rdata (cpu_rdata),
        .pal_addr  (pal_addr),
        .pal_data  (pal_data)
    );

    video_output #(
        .blank_dly (blank_dly)
    ) u_video_output (
        .clk      (clk),
        .reset    (reset),
        .pxl_cen  (pxl_cen),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .pal_data (pal_data),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly)
    );

endmodule

// File: dv/video_mixer_tb.sv
`timescale 1ns/100ps

module video_mixer_tb;

    localparam int pal_words  = 1024;
    localparam int wait_limit = 64;
    // pixel stimulus kinds
    localparam int mode_ba0    = 1;
    localparam int mode_scroll = 2;
    localparam int mode_sprite = 3;
    localparam int mode_gfx    = 4;
    localparam int mode_blank  = 5;

    logic        clk = 1'b0;
    logic        reset;
    logic        pxl_cen = 1'b0;
    logic [1:0]  cen_cnt = 2'd0;
    logic        lhbl;
    logic        lvbl;
    logic [7:0]  ba0_pxl;
    logic [7:0]  ba1_pxl;
    logic [7:0]  ba2_pxl;
    logic [7:0]  obj_pxl;
    logic [2:0]  prisel;
    logic [3:0]  gfx_en;
    logic [11:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [15:0] pwdata;
    logic [1:0]  pstrb;
    logic [15:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [7:0]  red;
    logic [7:0]  green;
    logic [7:0]  blue;
    logic        lhbl_dly;
    logic        lvbl_dly;

    // shadow of the palette, kept by the apb task
    logic [15:0] shadow [0:pal_words-1];
    // expected {lhbl, lvbl, r, g, b}, one and two enables back
    logic [25:0] exp_d1;
    logic [25:0] exp_d2;
    logic        vld_d1;
    logic        vld_d2;
    logic        chk_on;
    logic [15:0] exp_prdata;
    logic        exp_err;
    logic        timeout_hit;
    int          err_cnt;
    int          tests_run;
    int          tests_failed;
    int          e0;
    int unsigned seed_val;
    string       cur_test;

    video_mixer_top #(
        .blank_dly (2)
    ) u_dut (
        .clk      (clk),
        .reset    (reset),
        .pxl_cen  (pxl_cen),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .ba0_pxl  (ba0_pxl),
        .ba1_pxl  (ba1_pxl),
        .ba2_pxl  (ba2_pxl),
        .obj_pxl  (obj_pxl),
        .prisel   (prisel),
        .gfx_en   (gfx_en),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .pstrb    (pstrb),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly)
    );

    always #10 clk = ~clk;

    // one pixel enable every 4th clock
    always @(posedge clk) begin
        cen_cnt <= cen_cnt + 2'd1;
        pxl_cen <= (cen_cnt == 2'd2);
    end

    // layer choice from the priority rule, gives the palette index
    function automatic logic [9:0] pick_entry(
        input logic [7:0] b0,
        input logic [7:0] b1,
        input logic [7:0] b2,
        input logic [7:0] ob,
        input logic [2:0] ps,
        input logic [3:0] en
    );
        logic [7:0] front_px;
        logic [7:0] back_px;
        logic [7:0] scr_px;
        logic [1:0] front_bank;
        logic [1:0] back_bank;
        logic [1:0] scr_bank;
        logic       obj_low;
        if (ps[0]) begin
            front_px   = b2;
            front_bank = 2'd3;
            back_px    = b1;
            back_bank  = 2'd2;
        end else begin
            front_px   = b1;
            front_bank = 2'd2;
            back_px    = b2;
            back_bank  = 2'd3;
        end
        // front layer blank means fallback, even if that one is blank too
        if (front_px[3:0] == 4'd0 || !en[front_bank - 2'd1]) begin
            scr_px   = back_px;
            scr_bank = back_bank;
        end else begin
            scr_px   = front_px;
            scr_bank = front_bank;
        end
        obj_low = ps[1] && (ob[7] != ps[2]);
        if (b0[3:0] != 4'd0 && en[0]) begin
            pick_entry = {2'd1, b0};
        end else if (ob[3:0] != 4'd0 && en[3] && !(obj_low && scr_px[3:0] != 4'd0)) begin
            pick_entry = {2'd0, ob};
        end else begin
            pick_entry = {scr_bank, scr_px};
        end
    endfunction

    // nibble doubled per channel, black unless both strobes high
    function automatic logic [25:0] expect_out(
        input logic [15:0] word,
        input logic        hb,
        input logic        vb
    );
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
        r = word[3:0];
        g = word[7:4];
        b = word[11:8];
        if (hb && vb) begin
            expect_out = {hb, vb, r, r, g, g, b, b};
        end else begin
            expect_out = {hb, vb, 24'd0};
        end
    endfunction

    // reference pipeline, two enables deep like the DUT
    always @(posedge clk) begin
        if (reset) begin
            vld_d1 <= 1'b0;
            vld_d2 <= 1'b0;
        end else if (pxl_cen) begin
            exp_d1 <= expect_out(shadow[pick_entry(ba0_pxl, ba1_pxl, ba2_pxl, obj_pxl,
                                                   prisel, gfx_en)], lhbl, lvbl);
            exp_d2 <= exp_d1;
            vld_d1 <= chk_on;
            vld_d2 <= vld_d1;
        end
    end

    a_video_colour: assert property (
        @(posedge clk) disable iff (reset)
        (pxl_cen && vld_d2) |-> ({red, green, blue} == exp_d2[23:0])
    ) else begin
        err_cnt++;
        $display("error %s: rgb expected %h actual %h", cur_test,
                 $sampled(exp_d2[23:0]), $sampled({red, green, blue}));
    end

    a_video_blank: assert property (
        @(posedge clk) disable iff (reset)
        (pxl_cen && vld_d2) |-> ({lhbl_dly, lvbl_dly} == exp_d2[25:24])
    ) else begin
        err_cnt++;
        $display("error %s: strobes expected %b actual %b", cur_test,
                 $sampled(exp_d2[25:24]), $sampled({lhbl_dly, lvbl_dly}));
    end

    // no wait states, flags only in the access cycle
    a_apb_ready: assert property (
        @(posedge clk) disable iff (reset)
        (psel && penable) |-> (pready && pslverr == exp_err)
    ) else begin
        err_cnt++;
        $display("error %s: pready/pslverr expected 1/%b actual %b/%b", cur_test,
                 $sampled(exp_err), $sampled(pready), $sampled(pslverr));
    end

    a_apb_idle: assert property (
        @(posedge clk) disable iff (reset)
        !(psel && penable) |-> (!pready && !pslverr)
    ) else begin
        err_cnt++;
        $display("error %s: pready/pslverr expected 0/0 actual %b/%b", cur_test,
                 $sampled(pready), $sampled(pslverr));
    end

    a_apb_rdata: assert property (
        @(posedge clk) disable iff (reset)
        (psel && penable && !pwrite) |-> (prdata == exp_prdata)
    ) else begin
        err_cnt++;
        $display("error %s: prdata expected %h actual %h", cur_test,
                 $sampled(exp_prdata), $sampled(prdata));
    end

    // one apb transfer, setup then access until pready
    task automatic apb_xfer(
        input logic        wr,
        input logic [11:0] addr,
        input logic [15:0] data,
        input logic [1:0]  strb
    );
        int         n;
        logic       got;
        logic [9:0] idx;
        if (!timeout_hit) begin
            idx = addr[10:1];
            @(posedge clk);
            psel       <= 1'b1;
            penable    <= 1'b0;
            pwrite     <= wr;
            paddr      <= addr;
            pwdata     <= data;
            pstrb      <= strb;
            exp_err    <= addr[11];
            exp_prdata <= (wr || addr[11]) ? 16'd0 : shadow[idx];
            @(posedge clk);
            penable <= 1'b1;
            n = 0;
            got = 1'b0;
            while (!got && n < wait_limit) begin
                @(posedge clk);
                got = pready;
                n++;
            end
            psel    <= 1'b0;
            penable <= 1'b0;
            if (!got) begin
                timeout_hit = 1'b1;
                $display("timeout: pready never came for address %h", addr);
            end else if (wr && !addr[11]) begin
                if (strb[0]) begin
                    shadow[idx][7:0] = data[7:0];
                end
                if (strb[1]) begin
                    shadow[idx][15:8] = data[15:8];
                end
            end
        end
    endtask

    // returns on the edge where the DUT takes a pixel
    task automatic wait_pixel();
        int   n;
        logic got;
        n = 0;
        got = timeout_hit;
        while (!got && n < wait_limit) begin
            @(posedge clk);
            got = pxl_cen;
            n++;
        end
        if (!got) begin
            timeout_hit = 1'b1;
            $display("timeout: pixel enable stopped");
        end
    endtask

    // random data mixed with the full address
    task automatic fill_palette();
        int unsigned r;
        for (int i = 0; i < pal_words; i++) begin
            r = $urandom;
            apb_xfer(1'b1, {1'b0, i[9:0], 1'b0}, r[15:0] ^ {6'd0, i[9:0]}, 2'b11);
        end
    endtask

    // odds: 0 never blank, 1 a quarter, 2 half
    function automatic logic [7:0] rand_pixel(input logic [1:0] odds);
        int unsigned r;
        logic [7:0]  px;
        r = $urandom;
        px = r[7:0];
        if (r[31:30] < odds) begin
            px[3:0] = 4'd0;
        end else if (px[3:0] == 4'd0) begin
            px[3:0] = 4'd1;
        end
        rand_pixel = px;
    endfunction

    task automatic drive_pixels(input int mode, input int count);
        int unsigned r;
        for (int k = 0; k < count; k++) begin
            wait_pixel();
            r = $urandom;
            chk_on  <= 1'b1;
            lhbl    <= 1'b1;
            lvbl    <= 1'b1;
            ba0_pxl <= rand_pixel(2'd1);
            ba1_pxl <= rand_pixel(2'd1);
            ba2_pxl <= rand_pixel(2'd1);
            obj_pxl <= rand_pixel(2'd1);
            prisel  <= r[2:0];
            gfx_en  <= 4'b1111;
            case (mode)
                mode_ba0: begin
                    ba0_pxl <= rand_pixel(2'd0);
                    gfx_en  <= {r[5:3], 1'b1};
                end
                mode_scroll: begin
                    // text and sprite clear, scroll half blank
                    ba0_pxl <= {r[7:4], 4'd0};
                    obj_pxl <= {r[11:8], 4'd0};
                    ba1_pxl <= rand_pixel(2'd2);
                    ba2_pxl <= rand_pixel(2'd2);
                    prisel  <= {r[13:12], k[0]};
                end
                mode_sprite: begin
                    ba0_pxl <= {r[7:4], 4'd0};
                    obj_pxl <= rand_pixel(2'd0);
                    prisel  <= {r[1], 1'b1, r[0]};
                end
                mode_gfx: begin
                    gfx_en <= r[6:3];
                end
                default: begin
                    lhbl <= r[8] | r[9];
                    lvbl <= r[10] | r[11] | r[12];
                end
            endcase
        end
        // let the last pixels reach the outputs
        for (int k = 0; k < 3; k++) begin
            wait_pixel();
        end
        chk_on <= 1'b0;
    endtask

    task automatic end_test(input int errs_before);
        tests_run++;
        if (err_cnt != errs_before || timeout_hit) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", cur_test, err_cnt - errs_before);
        end else begin
            $display("test %s: passed", cur_test);
        end
    endtask

    task automatic pixel_test(input string name, input int mode);
        cur_test = name;
        e0 = err_cnt;
        fill_palette();
        drive_pixels(mode, 400);
        end_test(e0);
    endtask

    initial begin
        seed_val = $urandom(32'hf72fc86e);
        reset = 1'b1;
        lhbl = 1'b0;
        lvbl = 1'b0;
        ba0_pxl = 8'd0;
        ba1_pxl = 8'd0;
        ba2_pxl = 8'd0;
        obj_pxl = 8'd0;
        prisel = 3'd0;
        gfx_en = 4'd0;
        paddr = 12'd0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = 16'd0;
        pstrb = 2'b00;
        exp_prdata = 16'd0;
        exp_err = 1'b0;
        chk_on = 1'b0;
        timeout_hit = 1'b0;
        err_cnt = 0;
        tests_run = 0;
        tests_failed = 0;
        cur_test = "reset";
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        cur_test = "apb_bytes";
        e0 = err_cnt;
        apb_xfer(1'b1, 12'h010, 16'h1234, 2'b11);
        apb_xfer(1'b1, 12'h7fe, 16'habcd, 2'b11);
        apb_xfer(1'b0, 12'h010, 16'd0, 2'b00);
        // single lane writes
        apb_xfer(1'b1, 12'h010, 16'h5a5a, 2'b01);
        apb_xfer(1'b1, 12'h7fe, 16'hc3c3, 2'b10);
        apb_xfer(1'b0, 12'h010, 16'd0, 2'b00);
        apb_xfer(1'b0, 12'h7fe, 16'd0, 2'b00);
        // beyond bit 10, aliases entry 8 but must not touch it
        apb_xfer(1'b1, 12'h810, 16'hffff, 2'b11);
        apb_xfer(1'b0, 12'h810, 16'd0, 2'b00);
        apb_xfer(1'b0, 12'h010, 16'd0, 2'b00);
        for (int i = 0; i < 24; i++) begin
            seed_val = $urandom;
            apb_xfer(1'b1, {1'b0, seed_val[9:0], 1'b0}, seed_val[31:16], 2'b11);
            apb_xfer(1'b1, {1'b0, seed_val[9:0], 1'b0}, ~seed_val[27:12], seed_val[11:10]);
            apb_xfer(1'b0, {1'b0, seed_val[9:0], 1'b0}, 16'd0, 2'b00);
        end
        end_test(e0);

        pixel_test("ba0_front", mode_ba0);
        pixel_test("scroll_swap", mode_scroll);
        pixel_test("sprite_priority", mode_sprite);
        pixel_test("gfx_enable", mode_gfx);
        pixel_test("blanking", mode_blank);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (tests_failed == 0 && err_cnt == 0 && !timeout_hit) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: src.f
logic/mixer_pkg.sv
logic/layer_priority.sv
logic/palette_apb_port.sv
logic/palette_ram.sv
logic/video_output.sv
logic/video_mixer_top.sv
dv/video_mixer_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the video mixer testbench with verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -j 0 \
    --top-module video_mixer_tb \
    --Mdir "$build_dir" \
    -f src.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/Vvideo_mixer_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
fi

# the log decides pass or fail
if grep -q "Test completed successfully" "$log_file"; then
    exit 0
fi
exit 1
